/* logic/aluPkg.sv */
`default_nettype none

package aluPkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;   // hi half on top
    typedef logic [4:0]  shamt_t;

    typedef enum logic [7:0] {
        opNop = 8'h00,
        opAnd,
        opOr,
        opNor,
        opXor,
        opAdd,
        opAddu,
        opSub,
        opSubu,
        opSlt,
        opSltu,
        opSllv,
        opSrlv,
        opSrav,
        opSll,
        opSrl,
        opSra,
        opRotr,
        opLui,
        opClo,
        opClz,
        opSeb,
        opSeh,
        opMult,
        opMultu,
        opDiv,
        opDivu,
        opMthi,
        opMtlo,
        opMfhi,
        opMflo
    } aluOp_t;

    typedef enum logic [1:0] {
        selBoth,
        selHi,
        selLo
    } hiloSel_t;

    // iterations per multi-cycle op
    localparam int mulCycles = 32;
    localparam int divCycles = 32;
    localparam int mulCntW = $clog2(mulCycles);
    localparam int divCntW = $clog2(divCycles);

    typedef logic [mulCntW-1:0] mulCnt_t;
    typedef logic [divCntW-1:0] divCnt_t;

endpackage

`default_nettype wire

/* logic/mulUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module mulUnit (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           flush_i,
    input  logic           start_i,
    input  logic           signed_i,
    input  logic           ack_i,
    input  aluPkg::word_t  opA_i,
    input  aluPkg::word_t  opB_i,
    output logic           ready_o,
    output aluPkg::dword_t result_o
);

    typedef enum logic [1:0] {stIdle, stBusy, stDone} state_t;

    state_t           state;
    aluPkg::mulCnt_t  count;
    aluPkg::dword_t   acc;
    aluPkg::dword_t   mcand;
    aluPkg::word_t    mplr;
    aluPkg::dword_t   accNext;
    aluPkg::word_t    magA;
    aluPkg::word_t    magB;
    logic             negate;
    logic             load;
    logic             last;

    // operate on magnitudes and fix the sign at the end
    assign magA = (signed_i && opA_i[31]) ? -opA_i : opA_i;
    assign magB = (signed_i && opB_i[31]) ? -opB_i : opB_i;

    assign load = (state == stIdle) && start_i;
    assign last = (state == stBusy) &&
                  (count == aluPkg::mulCnt_t'(aluPkg::mulCycles - 1));
    assign accNext = mplr[0] ? acc + mcand : acc;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            state <= stIdle;
            count <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (start_i) begin
                        state <= stBusy;
                        count <= '0;
                    end
                end
                stBusy: begin
                    if (!start_i) begin
                        state <= stIdle;   // op left execute
                    end else if (last) begin
                        state <= stDone;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                stDone: begin
                    if (ack_i || !start_i) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            acc    <= '0;
            mcand  <= {32'b0, magA};
            mplr   <= magB;
            negate <= signed_i && (opA_i[31] ^ opB_i[31]);
        end else if (state == stBusy) begin
            acc   <= (last && negate) ? -accNext : accNext;
            mcand <= mcand << 1;
            mplr  <= mplr >> 1;
        end
    end

    assign ready_o  = (state == stDone);
    assign result_o = acc;

    // product stays put until the ALU takes it
    assert property (@(posedge clk) disable iff (reset_i)
        ready_o && start_i && !ack_i && !flush_i |=> ready_o && $stable(result_o));

endmodule

`default_nettype wire

/* logic/divUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module divUnit (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           flush_i,
    input  logic           start_i,
    input  logic           signed_i,
    input  logic           ack_i,
    input  aluPkg::word_t  opA_i,
    input  aluPkg::word_t  opB_i,
    output logic           ready_o,
    output aluPkg::dword_t result_o
);

    typedef enum logic [1:0] {stIdle, stBusy, stFix, stDone} state_t;

    state_t           state;
    aluPkg::divCnt_t  count;
    aluPkg::word_t    quo;
    aluPkg::word_t    rem;
    aluPkg::word_t    divisor;
    aluPkg::word_t    magA;
    aluPkg::word_t    magB;
    logic [32:0]      partial;
    logic             fits;
    logic             negQuo;
    logic             negRem;
    logic             load;
    logic             zeroDiv;
    logic             last;

    assign magA = (signed_i && opA_i[31]) ? -opA_i : opA_i;
    assign magB = (signed_i && opB_i[31]) ? -opB_i : opB_i;

    assign load    = (state == stIdle) && start_i;
    assign zeroDiv = (opB_i == '0);
    assign last    = (state == stBusy) &&
                     (count == aluPkg::divCnt_t'(aluPkg::divCycles - 1));

    // shift in next dividend bit and try the subtract
    assign partial = {rem, quo[31]};
    assign fits    = (partial >= {1'b0, divisor});

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            state <= stIdle;
            count <= '0;
        end else begin
            case (state)
                stIdle: begin
                    if (start_i) begin
                        state <= zeroDiv ? stDone : stBusy;
                        count <= '0;
                    end
                end
                stBusy: begin
                    if (!start_i) begin
                        state <= stIdle;
                    end else if (last) begin
                        state <= stFix;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                stFix: begin
                    state <= start_i ? stDone : stIdle;
                end
                stDone: begin
                    if (ack_i || !start_i) begin
                        state <= stIdle;
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            if (zeroDiv) begin
                rem <= opA_i;   // div by zero result
                quo <= '1;
            end else begin
                rem <= '0;
                quo <= magA;
            end
            divisor <= magB;
            negQuo  <= signed_i && (opA_i[31] ^ opB_i[31]);
            negRem  <= signed_i && opA_i[31];
        end else if (state == stBusy) begin
            rem <= fits ? aluPkg::word_t'(partial - {1'b0, divisor}) : partial[31:0];
            quo <= {quo[30:0], fits};
        end else if (state == stFix) begin
            if (negQuo) begin
                quo <= -quo;
            end
            if (negRem) begin
                rem <= -rem;   // remainder follows dividend
            end
        end
    end

    assign ready_o  = (state == stDone);
    assign result_o = {rem, quo};

    // zero divisors must bypass the iteration
    assert property (@(posedge clk) disable iff (reset_i)
        (state == stBusy) |-> (divisor != '0));

endmodule

`default_nettype wire

/* logic/hiloReg.sv */
`timescale 1ns/10ps
`default_nettype none

module hiloReg (
    input  logic             clk,
    input  logic             reset_i,
    input  logic             we_i,
    input  aluPkg::hiloSel_t sel_i,
    input  aluPkg::dword_t   wdata_i,
    output aluPkg::word_t    hi_o,
    output aluPkg::word_t    lo_o
);

    aluPkg::word_t hiQ;
    aluPkg::word_t loQ;
    logic          hiWe;
    logic          loWe;

    assign hiWe = we_i && ((sel_i == aluPkg::selBoth) || (sel_i == aluPkg::selHi));
    assign loWe = we_i && ((sel_i == aluPkg::selBoth) || (sel_i == aluPkg::selLo));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hiQ <= '0;
            loQ <= '0;
        end else begin
            if (hiWe) begin
                hiQ <= wdata_i[63:32];
            end
            if (loWe) begin
                loQ <= wdata_i[31:0];
            end
        end
    end

    // read straight from the flops
    assign hi_o = hiQ;
    assign lo_o = loQ;

endmodule

`default_nettype wire

/* logic/execAlu.sv */
`timescale 1ns/10ps
`default_nettype none

module execAlu (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           stall_i,
    input  logic           flush_i,
    input  logic           exceptionFlush_i,
    input  aluPkg::word_t  srcA_i,
    input  aluPkg::word_t  srcB_i,
    input  aluPkg::shamt_t shamt_i,
    input  aluPkg::aluOp_t op_i,
    output aluPkg::dword_t result_o,
    output logic           stall_o,
    output logic           overflow_o
);

    typedef struct packed {
        logic start;
        logic sign;
        logic ack;
    } unitCtl_t;

    typedef struct packed {
        logic             we;
        aluPkg::hiloSel_t sel;
    } hiloWr_t;

    aluPkg::dword_t mulResult;
    aluPkg::dword_t divResult;
    aluPkg::dword_t aluResult;
    aluPkg::word_t  hiVal;
    aluPkg::word_t  loVal;
    aluPkg::word_t  rotr;
    logic [32:0]    addSum;
    logic [32:0]    subDiff;
    logic           mulReady;
    logic           divReady;
    logic           isMul;
    logic           isDiv;
    logic           hiloWe;
    unitCtl_t       mulCtl;
    unitCtl_t       divCtl;
    hiloWr_t        hiloReq;

    function automatic aluPkg::dword_t lowWord(aluPkg::word_t w);
        return {32'b0, w};
    endfunction

    // length of the leading run of bitVal, up to 32
    function automatic aluPkg::word_t countLead(aluPkg::word_t w, logic bitVal);
        aluPkg::word_t n;
        logic          stop;
        n = 32'd32;
        stop = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (!stop && (w[i] != bitVal)) begin
                n = aluPkg::word_t'(31 - i);
                stop = 1'b1;
            end
        end
        return n;
    endfunction

    assign isMul = (op_i == aluPkg::opMult) || (op_i == aluPkg::opMultu);
    assign isDiv = (op_i == aluPkg::opDiv) || (op_i == aluPkg::opDivu);

    // start stays up until the result is taken
    assign mulCtl = '{start: isMul,
                      sign:  (op_i == aluPkg::opMult),
                      ack:   mulReady && !stall_i};
    assign divCtl = '{start: isDiv,
                      sign:  (op_i == aluPkg::opDiv),
                      ack:   divReady && !stall_i};

    assign addSum  = {srcA_i[31], srcA_i} + {srcB_i[31], srcB_i};
    assign subDiff = {srcA_i[31], srcA_i} - {srcB_i[31], srcB_i};
    assign rotr    = (srcB_i >> shamt_i) | (srcB_i << (6'd32 - {1'b0, shamt_i}));

    always_comb begin
        aluResult   = '0;
        stall_o     = 1'b0;
        overflow_o  = 1'b0;
        hiloReq.we  = 1'b0;
        hiloReq.sel = aluPkg::selBoth;
        case (op_i)
            aluPkg::opAnd:  aluResult = lowWord(srcA_i & srcB_i);
            aluPkg::opOr:   aluResult = lowWord(srcA_i | srcB_i);
            aluPkg::opNor:  aluResult = lowWord(~(srcA_i | srcB_i));
            aluPkg::opXor:  aluResult = lowWord(srcA_i ^ srcB_i);
            aluPkg::opAdd: begin
                aluResult  = lowWord(addSum[31:0]);
                overflow_o = addSum[32] ^ addSum[31];   // sign bits disagree
            end
            aluPkg::opAddu: aluResult = lowWord(srcA_i + srcB_i);
            aluPkg::opSub: begin
                aluResult  = lowWord(subDiff[31:0]);
                overflow_o = subDiff[32] ^ subDiff[31];
            end
            aluPkg::opSubu: aluResult = lowWord(srcA_i - srcB_i);
            aluPkg::opSlt:  aluResult = lowWord({31'b0, $signed(srcA_i) < $signed(srcB_i)});
            aluPkg::opSltu: aluResult = lowWord({31'b0, srcA_i < srcB_i});
            aluPkg::opSllv: aluResult = lowWord(srcB_i << srcA_i[4:0]);
            aluPkg::opSrlv: aluResult = lowWord(srcB_i >> srcA_i[4:0]);
            aluPkg::opSrav: aluResult = lowWord($signed(srcB_i) >>> srcA_i[4:0]);
            aluPkg::opSll:  aluResult = lowWord(srcB_i << shamt_i);
            aluPkg::opSrl:  aluResult = lowWord(srcB_i >> shamt_i);
            aluPkg::opSra:  aluResult = lowWord($signed(srcB_i) >>> shamt_i);
            aluPkg::opRotr: aluResult = lowWord(rotr);
            aluPkg::opLui:  aluResult = lowWord({srcB_i[15:0], 16'b0});
            aluPkg::opClo:  aluResult = lowWord(countLead(srcA_i, 1'b1));
            aluPkg::opClz:  aluResult = lowWord(countLead(srcA_i, 1'b0));
            aluPkg::opSeb:  aluResult = lowWord({{24{srcB_i[7]}}, srcB_i[7:0]});
            aluPkg::opSeh:  aluResult = lowWord({{16{srcB_i[15]}}, srcB_i[15:0]});
            aluPkg::opMult, aluPkg::opMultu: begin
                stall_o    = !mulReady;
                aluResult  = mulReady ? mulResult : '0;
                hiloReq.we = mulCtl.ack;
            end
            aluPkg::opDiv, aluPkg::opDivu: begin
                stall_o    = !divReady;
                aluResult  = divReady ? divResult : '0;
                hiloReq.we = divCtl.ack;
            end
            aluPkg::opMthi: begin
                aluResult   = {srcA_i, 32'b0};
                hiloReq.sel = aluPkg::selHi;
                hiloReq.we  = !stall_i;
            end
            aluPkg::opMtlo: begin
                aluResult   = lowWord(srcA_i);
                hiloReq.sel = aluPkg::selLo;
                hiloReq.we  = !stall_i;
            end
            aluPkg::opMfhi: aluResult = lowWord(hiVal);
            aluPkg::opMflo: aluResult = lowWord(loVal);
            default:        aluResult = '0;   // nop and unknown codes
        endcase
    end

    assign result_o = aluResult;

    // a later-stage exception kills the write
    assign hiloWe = hiloReq.we && !exceptionFlush_i;

    mulUnit uMul (
        .clk      (clk),
        .reset_i  (reset_i),
        .flush_i  (flush_i),
        .start_i  (mulCtl.start),
        .signed_i (mulCtl.sign),
        .ack_i    (mulCtl.ack),
        .opA_i    (srcA_i),
        .opB_i    (srcB_i),
        .ready_o  (mulReady),
        .result_o (mulResult)
    );

    divUnit uDiv (
        .clk      (clk),
        .reset_i  (reset_i),
        .flush_i  (flush_i),
        .start_i  (divCtl.start),
        .signed_i (divCtl.sign),
        .ack_i    (divCtl.ack),
        .opA_i    (srcA_i),
        .opB_i    (srcB_i),
        .ready_o  (divReady),
        .result_o (divResult)
    );

    hiloReg uHilo (
        .clk      (clk),
        .reset_i  (reset_i),
        .we_i     (hiloWe),
        .sel_i    (hiloReq.sel),
        .wdata_i  (aluResult),
        .hi_o     (hiVal),
        .lo_o     (loVal)
    );

    // HI/LO must not move across a cycle with an exception flush
    assert property (@(posedge clk) disable iff (reset_i)
        exceptionFlush_i |=> ($stable(hiVal) && $stable(loVal)));

endmodule

`default_nettype wire

/* test/execAluTb.sv */
`timescale 1ns/10ps
`default_nettype none

module execAluTb;

    typedef struct packed {
        aluPkg::aluOp_t op;
        aluPkg::word_t  a;
        aluPkg::word_t  b;
        aluPkg::shamt_t sh;
        logic [3:0]     hold;        // ready cycles with stall_i high
        logic           exf;
        logic [5:0]     flushAfter;  // 0 means no flush
    } row_t;

    logic           clk;
    logic           reset_i;
    logic           stall_i;
    logic           flush_i;
    logic           exceptionFlush_i;
    aluPkg::word_t  srcA_i;
    aluPkg::word_t  srcB_i;
    aluPkg::shamt_t shamt_i;
    aluPkg::aluOp_t op_i;
    aluPkg::dword_t result_o;
    logic           stall_o;
    logic           overflow_o;

    row_t           rows[$];
    string          names[$];
    aluPkg::word_t  hiModel;
    aluPkg::word_t  loModel;
    aluPkg::word_t  lfsrState = 32'hb4821432;
    int             cycles = 0;

    execAlu DUT (
        .clk              (clk),
        .reset_i          (reset_i),
        .stall_i          (stall_i),
        .flush_i          (flush_i),
        .exceptionFlush_i (exceptionFlush_i),
        .srcA_i           (srcA_i),
        .srcB_i           (srcB_i),
        .shamt_i          (shamt_i),
        .op_i             (op_i),
        .result_o         (result_o),
        .stall_o          (stall_o),
        .overflow_o       (overflow_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > rows.size() * 45 + 50) begin
            $display("Timeout: the run went past %0d cycles", cycles - 1);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    function automatic aluPkg::word_t lfsrStep(aluPkg::word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
    endfunction

    task automatic drawWord(output aluPkg::word_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsrState = lfsrStep(lfsrState);
            w = {w[30:0], lfsrState[0]};
        end
    endtask

    task automatic addRow(string name, aluPkg::aluOp_t op, aluPkg::word_t a, aluPkg::word_t b,
                          aluPkg::shamt_t sh = '0, int hold = 0, bit exf = 0,
                          int flushAfter = 0);
        row_t r;
        r.op = op;
        r.a = a;
        r.b = b;
        r.sh = sh;
        r.hold = hold[3:0];
        r.exf = exf;
        r.flushAfter = flushAfter[5:0];
        rows.push_back(r);
        names.push_back(name);
    endtask

    function automatic aluPkg::word_t leadingRun(aluPkg::word_t w, logic v);
        int n;
        n = 0;
        while (n < 32 && w[31 - n] == v) begin
            n++;
        end
        return aluPkg::word_t'(n);
    endfunction

    function automatic logic isMulDiv(aluPkg::aluOp_t op);
        return op inside {aluPkg::opMult, aluPkg::opMultu, aluPkg::opDiv, aluPkg::opDivu};
    endfunction

    // expected 64-bit result with the hi half on top
    function automatic aluPkg::dword_t modelResult(row_t r, aluPkg::word_t hi,
                                                   aluPkg::word_t lo);
        longint        sa;
        longint        sb;
        aluPkg::word_t a;
        aluPkg::word_t b;
        a = r.a;
        b = r.b;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        case (r.op)
            aluPkg::opAnd:                  return {32'b0, a & b};
            aluPkg::opOr:                   return {32'b0, a | b};
            aluPkg::opNor:                  return {32'b0, ~(a | b)};
            aluPkg::opXor:                  return {32'b0, a ^ b};
            aluPkg::opAdd, aluPkg::opAddu:  return {32'b0, a + b};
            aluPkg::opSub, aluPkg::opSubu:  return {32'b0, a - b};
            aluPkg::opSlt:                  return (sa < sb) ? 64'd1 : 64'd0;
            aluPkg::opSltu:                 return (a < b) ? 64'd1 : 64'd0;
            aluPkg::opSllv:                 return {32'b0, b << a[4:0]};
            aluPkg::opSrlv:                 return {32'b0, b >> a[4:0]};
            aluPkg::opSrav:                 return {32'b0, aluPkg::word_t'(sb >>> a[4:0])};
            aluPkg::opSll:                  return {32'b0, b << r.sh};
            aluPkg::opSrl:                  return {32'b0, b >> r.sh};
            aluPkg::opSra:                  return {32'b0, aluPkg::word_t'(sb >>> r.sh)};
            aluPkg::opRotr:                 return {32'b0, aluPkg::word_t'({b, b} >> r.sh)};
            aluPkg::opLui:                  return {32'b0, b[15:0], 16'b0};
            aluPkg::opClo:                  return {32'b0, leadingRun(a, 1'b1)};
            aluPkg::opClz:                  return {32'b0, leadingRun(a, 1'b0)};
            aluPkg::opSeb:                  return {32'b0, {24{b[7]}}, b[7:0]};
            aluPkg::opSeh:                  return {32'b0, {16{b[15]}}, b[15:0]};
            aluPkg::opMult:                 return aluPkg::dword_t'(sa * sb);
            aluPkg::opMultu:                return {32'b0, a} * {32'b0, b};
            aluPkg::opDiv: begin
                if (b == '0) begin
                    return {a, 32'hffffffff};
                end
                return {aluPkg::word_t'(sa % sb), aluPkg::word_t'(sa / sb)};
            end
            aluPkg::opDivu: begin
                if (b == '0) begin
                    return {a, 32'hffffffff};
                end
                return {a % b, a / b};
            end
            aluPkg::opMthi:                 return {a, 32'b0};
            aluPkg::opMtlo:                 return {32'b0, a};
            aluPkg::opMfhi:                 return {32'b0, hi};
            aluPkg::opMflo:                 return {32'b0, lo};
            default:                        return '0;
        endcase
    endfunction

    // signed overflow when the true sum leaves the 32-bit range
    function automatic logic modelOverflow(row_t r);
        longint s;
        if (r.op == aluPkg::opAdd) begin
            s = longint'($signed(r.a)) + longint'($signed(r.b));
        end else if (r.op == aluPkg::opSub) begin
            s = longint'($signed(r.a)) - longint'($signed(r.b));
        end else begin
            return 1'b0;
        end
        return s != longint'($signed(aluPkg::word_t'(s)));
    endfunction

    function automatic int expectLatency(row_t r);
        if (r.op == aluPkg::opMult || r.op == aluPkg::opMultu) begin
            return aluPkg::mulCycles + 1;
        end
        return (r.b == '0) ? 1 : aluPkg::divCycles + 2;  // zero divisor skips the loop
    endfunction

    task automatic checkDword(string name, aluPkg::dword_t expected, aluPkg::dword_t actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic checkBit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %b, actual %b", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic checkLatency(string name, int expected, int actual);
        if (actual != expected) begin
            $display("FAIL %s: expected %0d cycles, actual %0d cycles", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "latency mismatch");
        end
    endtask

    task automatic runRow(int idx);
        row_t           r;
        aluPkg::dword_t exp;
        logic           expOvf;
        int             waited;
        r = rows[idx];
        @(posedge clk);
        #1;
        op_i = r.op;
        srcA_i = r.a;
        srcB_i = r.b;
        shamt_i = r.sh;
        stall_i = (r.hold != 0);
        flush_i = 1'b0;
        exceptionFlush_i = r.exf;
        exp = modelResult(r, hiModel, loModel);
        expOvf = modelOverflow(r);
        #1;
        if (r.flushAfter != 0) begin
            repeat (r.flushAfter) @(posedge clk);
            #1;
            flush_i = 1'b1;  // unit aborts at the next edge
            #1;
            checkBit({names[idx], " stall"}, 1'b1, stall_o);
        end else begin
            if (!isMulDiv(r.op)) begin
                checkBit({names[idx], " stall"}, 1'b0, stall_o);
            end
            waited = 0;
            while (stall_o) begin
                if (waited == 40) begin
                    $display("Test %s: stall_o still high after 40 cycles, no ready", names[idx]);
                    $display("Test failures found");
                    $fatal(1, "missing ready");
                end
                @(posedge clk);
                #2;
                waited++;
            end
            if (isMulDiv(r.op)) begin
                checkLatency(names[idx], expectLatency(r), waited);
            end
            checkDword(names[idx], exp, result_o);
            checkBit({names[idx], " overflow"}, expOvf, overflow_o);
            if (r.hold != 0) begin
                repeat (r.hold - 1) begin
                    @(posedge clk);
                    #2;
                    checkDword({names[idx], " held"}, exp, result_o);
                    checkBit({names[idx], " held stall"}, 1'b0, stall_o);
                end
                @(posedge clk);
                #1;
                stall_i = 1'b0;  // ack goes out this cycle
                #1;
                checkDword({names[idx], " released"}, exp, result_o);
            end
            if (!r.exf) begin
                if (isMulDiv(r.op)) begin
                    hiModel = exp[63:32];
                    loModel = exp[31:0];
                end else if (r.op == aluPkg::opMthi) begin
                    hiModel = r.a;
                end else if (r.op == aluPkg::opMtlo) begin
                    loModel = r.a;
                end
            end
        end
    endtask

    task automatic buildTable();
        aluPkg::aluOp_t randOps[9];
        aluPkg::word_t  a;
        aluPkg::word_t  b;
        addRow("and", aluPkg::opAnd, 32'hf0f01234, 32'h0ff0ffff);
        addRow("or", aluPkg::opOr, 32'hf0f01234, 32'h0ff00001);
        addRow("nor", aluPkg::opNor, 32'hf0f01234, 32'h0ff00001);
        addRow("xor", aluPkg::opXor, 32'hffff0000, 32'h0ff00ff0);
        addRow("add", aluPkg::opAdd, 32'h12345678, 32'h11111111);
        addRow("addOvfPos", aluPkg::opAdd, 32'h7fffffff, 32'h00000001);
        addRow("addOvfNeg", aluPkg::opAdd, 32'h80000000, 32'hffffffff);
        addRow("addu", aluPkg::opAddu, 32'h7fffffff, 32'h00000001);
        addRow("sub", aluPkg::opSub, 32'h00000005, 32'h00000007);
        addRow("subOvfNeg", aluPkg::opSub, 32'h80000000, 32'h00000001);
        addRow("subOvfPos", aluPkg::opSub, 32'h7fffffff, 32'hffffffff);
        addRow("subu", aluPkg::opSubu, 32'h80000000, 32'h00000001);
        addRow("slt", aluPkg::opSlt, 32'hffffffff, 32'h00000001);
        addRow("sltu", aluPkg::opSltu, 32'hffffffff, 32'h00000001);
        addRow("sllv", aluPkg::opSllv, 32'h00000024, 32'h8000000f);
        addRow("srlv", aluPkg::opSrlv, 32'h00000018, 32'hf1234567);
        addRow("srav", aluPkg::opSrav, 32'h0000001f, 32'h80000000);
        addRow("sll", aluPkg::opSll, 32'h0, 32'h00ff00ff, 5'd8);
        addRow("srl", aluPkg::opSrl, 32'h0, 32'h80000000, 5'd31);
        addRow("sra", aluPkg::opSra, 32'h0, 32'hf0000000, 5'd4);
        addRow("rotr", aluPkg::opRotr, 32'h0, 32'h12345678, 5'd12);
        addRow("rotrZero", aluPkg::opRotr, 32'h0, 32'h12345678, 5'd0);
        addRow("lui", aluPkg::opLui, 32'h0, 32'h1234beef);
        addRow("cloAll", aluPkg::opClo, 32'hffffffff, 32'h0);
        addRow("clo", aluPkg::opClo, 32'hff00ff00, 32'h0);
        addRow("clzAll", aluPkg::opClz, 32'h00000000, 32'h0);
        addRow("clz", aluPkg::opClz, 32'h00010000, 32'h0);
        addRow("seb", aluPkg::opSeb, 32'h0, 32'h12345680);
        addRow("seh", aluPkg::opSeh, 32'h0, 32'h12348000);
        addRow("multMin", aluPkg::opMult, 32'h80000000, 32'h80000000);
        addRow("multNeg", aluPkg::opMult, 32'hfffffffd, 32'h00000007);
        addRow("mfhiMult", aluPkg::opMfhi, 32'h0, 32'h0);
        addRow("multuMax", aluPkg::opMultu, 32'hffffffff, 32'hffffffff);
        addRow("mfloMultu", aluPkg::opMflo, 32'h0, 32'h0);
        addRow("divNeg", aluPkg::opDiv, 32'hfffffff9, 32'h00000002);
        addRow("divMixed", aluPkg::opDiv, 32'h00000007, 32'hfffffffe);
        addRow("mfhiDiv", aluPkg::opMfhi, 32'h0, 32'h0);
        addRow("divZero", aluPkg::opDiv, 32'h12345678, 32'h0);
        addRow("mfloDivZero", aluPkg::opMflo, 32'h0, 32'h0);
        addRow("divu", aluPkg::opDivu, 32'hffffffff, 32'h00000003);
        addRow("mthi", aluPkg::opMthi, 32'hcafef00d, 32'h0);
        addRow("mtlo", aluPkg::opMtlo, 32'h0badc0de, 32'h0);
        addRow("mthiExc", aluPkg::opMthi, 32'h55555555, 32'h0, 5'd0, 0, 1'b1);
        addRow("mtloExc", aluPkg::opMtlo, 32'h66666666, 32'h0, 5'd0, 0, 1'b1);
        addRow("mfhiMt", aluPkg::opMfhi, 32'h0, 32'h0);
        addRow("mfloMt", aluPkg::opMflo, 32'h0, 32'h0);
        addRow("multHold", aluPkg::opMult, 32'h00012345, 32'hfff00001, 5'd0, 3);
        addRow("mfhiHold", aluPkg::opMfhi, 32'h0, 32'h0);
        addRow("divFlush", aluPkg::opDiv, 32'h00001000, 32'h00000007, 5'd0, 0, 1'b0, 10);
        addRow("mfloFlush", aluPkg::opMflo, 32'h0, 32'h0);
        // the next divide keeps start high, so only the flush restarts the unit
        addRow("divuFlush", aluPkg::opDivu, 32'h00009000, 32'h00000005, 5'd0, 0, 1'b0, 20);
        addRow("divuAfter", aluPkg::opDivu, 32'h00000064, 32'h00000007);
        addRow("mfhiAfter", aluPkg::opMfhi, 32'h0, 32'h0);
        addRow("nop", aluPkg::opNop, 32'hffffffff, 32'hffffffff);
        randOps = '{aluPkg::opAdd, aluPkg::opSub, aluPkg::opMult, aluPkg::opMfhi,
                    aluPkg::opMultu, aluPkg::opDiv, aluPkg::opMflo, aluPkg::opDivu,
                    aluPkg::opMfhi};
        for (int n = 0; n < 18; n++) begin
            drawWord(a);
            drawWord(b);
            addRow($sformatf("rand%0d", n), randOps[n % 9], a, b);
        end
    endtask

    initial begin
        reset_i = 1'b1;
        stall_i = 1'b0;
        flush_i = 1'b0;
        exceptionFlush_i = 1'b0;
        srcA_i = '0;
        srcB_i = '0;
        shamt_i = '0;
        op_i = aluPkg::opNop;
        hiModel = '0;
        loModel = '0;
        buildTable();
        repeat (3) @(posedge clk);
        #1;
        reset_i = 1'b0;
        #1;
        checkBit("resetStall", 1'b0, stall_o);
        for (int i = 0; i < rows.size(); i++) begin
            runRow(i);
        end
        @(posedge clk);
        #1;
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
logic/aluPkg.sv
logic/mulUnit.sv
logic/divUnit.sv
logic/hiloReg.sv
logic/execAlu.sv
test/execAluTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f vlog.f --top-module execAluTb -o simv

output=$(./obj_dir/simv 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1
